//--- hw/resonator_pkg.sv
package resonator_pkg;

	// ----------------------------------------------------------------------
	// Sizes and address map
	// ----------------------------------------------------------------------
	localparam int HARM_MAX = 25;
	localparam int ADDR_W = 5;
	localparam int HCNT_W = 5;
	localparam int FRAC_BITS = 16;
	localparam int SAMPLE_W = 18;
	localparam int WORD_W = 2 * SAMPLE_W;
	localparam int ACC_W = 38;

	// Operands arrive this many cycles after the read address
	localparam int MAC_DELAY = 2;

	// ----------------------------------------------------------------------
	// Types
	// ----------------------------------------------------------------------
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [HCNT_W-1:0] hcnt_t;

	// Common word sits right above the last harmonic
	localparam addr_t COMMON_ADDR = addr_t'(HARM_MAX);

	typedef enum logic [1:0] {
		OP_IDLE,
		OP_HARM,
		OP_SUM
	} mac_op_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_RUN,
		ST_DRAIN
	} seq_state_e;

endpackage

//--- hw/mac_ctrl_if.sv
interface mac_ctrl_if;
	import resonator_pkg::*;

	// One datapath operation per cycle, valid when op is not OP_IDLE
	mac_op_e op;
	addr_t waddr;
	logic first;
	sample_t e;

	modport seq (
		output op,
		output waddr,
		output first,
		output e
	);

	modport mac (
		input op,
		input waddr,
		input first,
		input e
	);

endinterface

//--- hw/resonator_sequencer.sv
module resonator_sequencer (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_i,
	input resonator_pkg::word_t coef_rdata_i,
	output resonator_pkg::addr_t coef_raddr_o,
	output resonator_pkg::addr_t state_raddr_o,
	output logic busy_o,
	mac_ctrl_if.seq ctrl
);
	import resonator_pkg::*;

	seq_state_e state_q;
	hcnt_t hidx_q;
	hcnt_t last_q;
	hcnt_t cnt_raw;
	hcnt_t last_idx;
	logic [$clog2(MAC_DELAY + 2)-1:0] wait_q;
	addr_t raddr_q;
	logic busy_q;
	logic load_done;
	logic run_last;

	// Both memories are read at the same index
	assign coef_raddr_o = raddr_q;
	assign state_raddr_o = raddr_q;
	assign ctrl.waddr = raddr_q;
	assign busy_o = busy_q;

	assign load_done = (state_q == ST_LOAD) && (wait_q == MAC_DELAY);
	assign run_last = (state_q == ST_RUN) && (hidx_q == last_q);

	// Clamp the harmonic count, 0 still runs one harmonic
	assign cnt_raw = coef_rdata_i[HCNT_W-1:0];
	always_comb begin
		if (cnt_raw == '0)
			last_idx = '0;
		else if (cnt_raw > HARM_MAX)
			last_idx = hcnt_t'(HARM_MAX - 1);
		else
			last_idx = cnt_raw - 1'b1;
	end

	// ----------------------------------------------------------------------
	// Frame FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_q <= ST_IDLE;
			busy_q <= 1'b0;
			wait_q <= '0;
			hidx_q <= '0;
			ctrl.op <= OP_IDLE;
		end else begin
			ctrl.op <= OP_IDLE;
			wait_q <= wait_q + 1'b1;
			case (state_q)
				ST_IDLE: begin
					if (start_i) begin
						state_q <= ST_LOAD;
						busy_q <= 1'b1;
						wait_q <= '0;
					end
				end
				ST_LOAD: begin
					if (load_done) begin
						state_q <= ST_RUN;
						hidx_q <= '0;
						ctrl.op <= OP_HARM;
					end
				end
				ST_RUN: begin
					if (run_last) begin
						state_q <= ST_DRAIN;
						wait_q <= '0;
						ctrl.op <= OP_SUM;
					end else begin
						hidx_q <= hidx_q + 1'b1;
						ctrl.op <= OP_HARM;
					end
				end
				default: begin
					// Let the sum write leave the MAC before dropping busy
					if (wait_q == MAC_DELAY + 1) begin
						state_q <= ST_IDLE;
						busy_q <= 1'b0;
					end
				end
			endcase
		end
	end

	// Addresses and frame constants
	always_ff @(posedge clk_i) begin
		ctrl.first <= load_done;
		if (state_q == ST_IDLE)
			raddr_q <= COMMON_ADDR;
		if (load_done) begin
			last_q <= last_idx;
			ctrl.e <= coef_rdata_i[WORD_W-1:SAMPLE_W];
			raddr_q <= '0;
		end
		if (state_q == ST_RUN) begin
			if (run_last)
				raddr_q <= COMMON_ADDR;
			else
				raddr_q <= addr_t'(hidx_q + 1'b1);
		end
	end

	a_busy_state: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		(state_q != ST_IDLE) |-> busy_o)
		else $error("busy_o low while frame active");

	a_hidx_range: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		hidx_q < HARM_MAX)
		else $error("harmonic counter out of range");

endmodule

//--- hw/coef_ram.sv
module coef_ram (
	input logic clk_i,
	input logic we_i,
	input resonator_pkg::addr_t waddr_i,
	input resonator_pkg::word_t wdata_i,
	input resonator_pkg::addr_t raddr_i,
	output resonator_pkg::word_t rdata_o,
	input logic busy_i
);
	import resonator_pkg::*;

	word_t mem [0:HARM_MAX];
	word_t rd_q;

	// Host write port
	always_ff @(posedge clk_i) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
	end

	// Read register then output register
	always_ff @(posedge clk_i) begin
		rd_q <= mem[raddr_i];
		rdata_o <= rd_q;
	end

	// Coefficients must stay stable for the whole frame
	a_no_write_busy: assert property (@(posedge clk_i)
		!(we_i && busy_i))
		else $error("coefficient write while busy");

endmodule

//--- hw/state_ram.sv
module state_ram (
	input logic clk_i,
	input logic we_i,
	input resonator_pkg::addr_t waddr_i,
	input resonator_pkg::word_t wdata_i,
	input resonator_pkg::addr_t raddr_i,
	output resonator_pkg::word_t rdata_o
);
	import resonator_pkg::*;

	word_t mem [0:HARM_MAX];
	word_t rd_q;

	// Resonators start from rest
	initial begin
		for (int i = 0; i <= HARM_MAX; i++) begin
			mem[i] = '0;
		end
	end

	// Writeback from the MAC
	always_ff @(posedge clk_i) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
	end

	// Same two-stage read as the coefficient memory
	always_ff @(posedge clk_i) begin
		rd_q <= mem[raddr_i];
		rdata_o <= rd_q;
	end

	a_waddr_range: assert property (@(posedge clk_i)
		we_i |-> (waddr_i <= HARM_MAX))
		else $error("state write address out of range");

endmodule

//--- hw/resonator_mac.sv
module resonator_mac (
	input logic clk_i,
	input logic harmonics_rst,
	mac_ctrl_if.mac ctrl,
	input resonator_pkg::word_t coef_i,
	input resonator_pkg::word_t state_i,
	output logic we_o,
	output resonator_pkg::addr_t waddr_o,
	output resonator_pkg::word_t wdata_o
);
	import resonator_pkg::*;

	mac_op_e op_d [MAC_DELAY];
	addr_t waddr_d [MAC_DELAY];
	logic first_d [MAC_DELAY];
	sample_t e_d [MAC_DELAY];

	mac_op_e op_now;
	sample_t c;
	sample_t s;
	sample_t x1;
	sample_t x2;
	sample_t new_x1;
	sample_t sum_q;
	acc_t prod_cx;
	acc_t prod_se;
	acc_t x2_sh;
	acc_t acc;
	logic seen_op;

	// ----------------------------------------------------------------------
	// Control delay, lines up with the registered memory reads
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			for (int i = 0; i < MAC_DELAY; i++)
				op_d[i] <= OP_IDLE;
		end else begin
			op_d[0] <= ctrl.op;
			for (int i = 1; i < MAC_DELAY; i++)
				op_d[i] <= op_d[i-1];
		end
	end

	always_ff @(posedge clk_i) begin
		waddr_d[0] <= ctrl.waddr;
		first_d[0] <= ctrl.first;
		e_d[0] <= ctrl.e;
		for (int i = 1; i < MAC_DELAY; i++) begin
			waddr_d[i] <= waddr_d[i-1];
			first_d[i] <= first_d[i-1];
			e_d[i] <= e_d[i-1];
		end
	end

	assign op_now = op_d[MAC_DELAY-1];

	// Operand split: coef word is {c, s}, state word is {x1, x2}
	assign c = coef_i[WORD_W-1:SAMPLE_W];
	assign s = coef_i[SAMPLE_W-1:0];
	assign x1 = state_i[WORD_W-1:SAMPLE_W];
	assign x2 = state_i[SAMPLE_W-1:0];

	assign prod_cx = c * x1;
	assign prod_se = s * e_d[MAC_DELAY-1];
	assign x2_sh = acc_t'(x2) <<< FRAC_BITS;
	assign acc = prod_cx - x2_sh + prod_se;

	// Arithmetic shift by FRAC_BITS then truncate
	assign new_x1 = acc[FRAC_BITS +: SAMPLE_W];

	// ----------------------------------------------------------------------
	// Result register and running sum
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (harmonics_rst)
			we_o <= 1'b0;
		else
			we_o <= (op_now != OP_IDLE);
	end

	always_ff @(posedge clk_i) begin
		waddr_o <= waddr_d[MAC_DELAY-1];
		if (op_now == OP_SUM)
			wdata_o <= {{SAMPLE_W{sum_q[SAMPLE_W-1]}}, sum_q};
		else
			wdata_o <= {new_x1, x1};
		// Wraps at 18 bits
		if (op_now == OP_HARM)
			sum_q <= first_d[MAC_DELAY-1] ? new_x1 : sum_q + new_x1;
	end

	always_ff @(posedge clk_i) begin
		if (harmonics_rst)
			seen_op <= 1'b0;
		else if (ctrl.op != OP_IDLE)
			seen_op <= 1'b1;
	end

	a_we_after_op: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		we_o |-> seen_op)
		else $error("state write without an issued operation");

endmodule

//--- hw/resonator_top.sv
module resonator_top (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_i,
	input logic coef_we_i,
	input resonator_pkg::addr_t coef_addr_i,
	input resonator_pkg::word_t coef_data_i,
	output logic busy_o,
	output logic res_we_o,
	output resonator_pkg::addr_t res_addr_o,
	output resonator_pkg::word_t res_data_o
);
	import resonator_pkg::*;

	addr_t coef_raddr;
	addr_t state_raddr;
	word_t coef_rdata;
	word_t state_rdata;

	mac_ctrl_if ctrl_if ();

	resonator_sequencer i_sequencer (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.start_i(start_i),
		.coef_rdata_i(coef_rdata),
		.coef_raddr_o(coef_raddr),
		.state_raddr_o(state_raddr),
		.busy_o(busy_o),
		.ctrl(ctrl_if.seq)
	);

	coef_ram i_coef_ram (
		.clk_i(clk_i),
		.we_i(coef_we_i),
		.waddr_i(coef_addr_i),
		.wdata_i(coef_data_i),
		.raddr_i(coef_raddr),
		.rdata_o(coef_rdata),
		.busy_i(busy_o)
	);

	// State write port is mirrored on the result outputs
	state_ram i_state_ram (
		.clk_i(clk_i),
		.we_i(res_we_o),
		.waddr_i(res_addr_o),
		.wdata_i(res_data_o),
		.raddr_i(state_raddr),
		.rdata_o(state_rdata)
	);

	resonator_mac i_mac (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.ctrl(ctrl_if.mac),
		.coef_i(coef_rdata),
		.state_i(state_rdata),
		.we_o(res_we_o),
		.waddr_o(res_addr_o),
		.wdata_o(res_data_o)
	);

endmodule

//--- test/tb_resonator_top.sv
module tb_resonator_top;
	timeunit 1ns;
	timeprecision 1ps;

	import resonator_pkg::*;

	logic clk_i;
	logic harmonics_rst;
	logic start_i;
	logic coef_we_i;
	addr_t coef_addr_i;
	word_t coef_data_i;
	logic busy_o;
	logic res_we_o;
	addr_t res_addr_o;
	word_t res_data_o;

	// Reference model of both memories
	sample_t c_m [HARM_MAX];
	sample_t s_m [HARM_MAX];
	sample_t x1_m [HARM_MAX];
	sample_t x2_m [HARM_MAX];
	sample_t e_m;
	hcnt_t cnt_m;

	addr_t exp_addr [$];
	word_t exp_data [$];
	logic started;
	logic busy_prev;
	logic [31:0] lfsr_q;

	resonator_top i_resonator_top (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.start_i(start_i),
		.coef_we_i(coef_we_i),
		.coef_addr_i(coef_addr_i),
		.coef_data_i(coef_data_i),
		.busy_o(busy_o),
		.res_we_o(res_we_o),
		.res_addr_o(res_addr_o),
		.res_data_o(res_data_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ----------------------------------------------------------------------
	// Failure reporting and random numbers
	// ----------------------------------------------------------------------
	task automatic fail_run(input string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (out)
			lfsr_q = lfsr_q ^ 32'h8020_0003;
		return out;
	endfunction

	function automatic sample_t rand_sample();
		sample_t r;
		r = '0;
		for (int i = 0; i < SAMPLE_W; i++)
			r = {r[SAMPLE_W-2:0], lfsr_bit()};
		return r;
	endfunction

	// ----------------------------------------------------------------------
	// Stimulus helpers that return 1 ns after a rising edge
	// ----------------------------------------------------------------------
	task automatic idle_cycles(input int cycles);
		repeat (cycles) @(posedge clk_i);
		#1;
	endtask

	task automatic write_coef(input addr_t addr, input word_t data);
		coef_we_i = 1'b1;
		coef_addr_i = addr;
		coef_data_i = data;
		@(posedge clk_i);
		#1;
		coef_we_i = 1'b0;
		if (addr == COMMON_ADDR) begin
			e_m = data[WORD_W-1:SAMPLE_W];
			cnt_m = data[HCNT_W-1:0];
		end else begin
			c_m[addr] = data[WORD_W-1:SAMPLE_W];
			s_m[addr] = data[SAMPLE_W-1:0];
		end
	endtask

	task automatic load_common(input hcnt_t cnt);
		write_coef(COMMON_ADDR, {rand_sample(), {(SAMPLE_W - HCNT_W){1'b0}}, cnt});
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (busy_o !== level && n < limit) begin
			@(posedge clk_i);
			#1;
			n++;
		end
		if (busy_o !== level)
			fail_run($sformatf("Timed out waiting for busy_o to become %0d", level));
	endtask

	// Resonator rule applied to the model with expected writes queued
	task automatic model_frame();
		int n;
		longint acc;
		sample_t nx;
		sample_t sum;
		if (cnt_m == '0)
			n = 1;
		else if (cnt_m > HARM_MAX)
			n = HARM_MAX;
		else
			n = cnt_m;
		sum = '0;
		for (int i = 0; i < n; i++) begin
			acc = longint'(c_m[i]) * longint'(x1_m[i])
				- (longint'(x2_m[i]) <<< FRAC_BITS)
				+ longint'(s_m[i]) * longint'(e_m);
			nx = sample_t'(acc >>> FRAC_BITS);
			sum = sum + nx;
			exp_addr.push_back(addr_t'(i));
			exp_data.push_back({nx, x1_m[i]});
			x2_m[i] = x1_m[i];
			x1_m[i] = nx;
		end
		exp_addr.push_back(COMMON_ADDR);
		exp_data.push_back({{SAMPLE_W{sum[SAMPLE_W-1]}}, sum});
	endtask

	task automatic run_frame(input bit poke);
		model_frame();
		started = 1'b1;
		start_i = 1'b1;
		@(posedge clk_i);
		#1;
		start_i = 1'b0;
		wait_busy(1'b1, 4);
		// A second start in mid frame must be ignored
		if (poke) begin
			idle_cycles(3);
			start_i = 1'b1;
			@(posedge clk_i);
			#1;
			start_i = 1'b0;
		end
		wait_busy(1'b0, 100);
		idle_cycles(4);
	endtask

	// ----------------------------------------------------------------------
	// Output monitor
	// ----------------------------------------------------------------------
	always @(negedge clk_i) begin
		if (!harmonics_rst) begin
			if (!started) begin
				assert (busy_o == 1'b0)
					else report_mismatch("busy_o", busy_o, 0);
				assert (res_we_o == 1'b0)
					else report_mismatch("res_we_o", res_we_o, 0);
			end
			if (res_we_o) begin
				assert (exp_addr.size() != 0)
					else fail_run("Result write seen when no write was expected");
				assert (res_addr_o == exp_addr[0])
					else report_mismatch("res_addr_o", res_addr_o, exp_addr[0]);
				assert (res_data_o == exp_data[0])
					else report_mismatch("res_data_o", res_data_o, exp_data[0]);
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
			if (busy_prev && !busy_o) begin
				assert (exp_addr.size() == 0)
					else fail_run($sformatf("busy_o fell with %0d writes missing",
						exp_addr.size()));
			end
			busy_prev = busy_o;
		end
	end

	initial begin
		harmonics_rst = 1'b1;
		start_i = 1'b0;
		coef_we_i = 1'b0;
		coef_addr_i = '0;
		coef_data_i = '0;
		started = 1'b0;
		busy_prev = 1'b0;
		lfsr_q = 32'h4aff;
		e_m = '0;
		cnt_m = '0;
		for (int i = 0; i < HARM_MAX; i++) begin
			x1_m[i] = '0;
			x2_m[i] = '0;
		end
		repeat (3) @(posedge clk_i);
		#1;
		harmonics_rst = 1'b0;
		idle_cycles(6);

		for (int i = 0; i < HARM_MAX; i++)
			write_coef(addr_t'(i), {rand_sample(), rand_sample()});

		// Three frames of three harmonics so states feed back through x2
		load_common(hcnt_t'(3));
		run_frame(1'b1);
		run_frame(1'b0);
		load_common(hcnt_t'(3));
		run_frame(1'b0);

		// Zero count still runs one harmonic
		load_common(hcnt_t'(0));
		run_frame(1'b0);

		// Count above the limit is clamped
		load_common(hcnt_t'(30));
		run_frame(1'b0);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- src.f
hw/resonator_pkg.sv
hw/mac_ctrl_if.sv
hw/resonator_sequencer.sv
hw/coef_ram.sv
hw/state_ram.sv
hw/resonator_mac.sv
hw/resonator_top.sv
test/tb_resonator_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_resonator_top -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
